// ==== nmr_acq_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface nmr_acq_if import nmr_seq_pkg::*; ();

	logic       sig_window; // high while the sequencer sits in the signal delay
	pulse_len_t rx_delay; // delayed receiver offset from window start
	pulse_len_t adc_init_delay; // adc window offset from window start
	count_t     samples_per_echo; // adc window length limit

	// sequencer side, all values held for the scan
	modport seq
	(
		output sig_window,
		output rx_delay,
		output adc_init_delay,
		output samples_per_echo
	);

	// acquisition timer side
	modport acq
	(
		input sig_window,
		input rx_delay,
		input adc_init_delay,
		input samples_per_echo
	);

endinterface

`default_nettype wire

// ==== nmr_acq_window.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nmr_cfg.svh"

module nmr_acq_window
	import nmr_seq_pkg::*;
	import nmr_data_pkg::*;
(
	input  wire              pulseprog_clk,
	input  wire              rst,
	input  wire adc_sample_t adc_in, // adc pins
	input  wire              adc_ov, // adc overflow pin
	nmr_acq_if.acq           acq,
	output logic             en_rx,
	output logic             en_rx_dly,
	output logic             en_adc, // conversion window
	output logic             adc_data_valid,
	output adc_word_t        adc_data_out,
	output logic             sample_valid,
	output adc_sample_t      sample,
	output logic             echo_first_sample
);

	localparam int LAT = `NMR_ADC_LATENCY;

	pulse_len_t           win_cnt; // cycles since the window opened
	logic                 adc_first; // first window cycle of the echo
	logic [LAT-1:0]       win_pipe; // en_adc delayed by the converter latency
	logic [LAT-1:0]       first_pipe; // first-sample flag alongside
	logic                 capture;

	// ========================================
	// receiver and adc windows
	// ========================================

	// zero on the rise cycle since it clears while the window is shut
	always_ff @(posedge pulseprog_clk)
	begin
		if (rst || !acq.sig_window)
			win_cnt <= '0;
		else
			win_cnt <= win_cnt + 1'b1;
	end

	assign en_rx = acq.sig_window;
	assign en_rx_dly = acq.sig_window && (win_cnt >= acq.rx_delay);
	assign en_adc = acq.sig_window && (win_cnt >= acq.adc_init_delay) &&
		((win_cnt - acq.adc_init_delay) < acq.samples_per_echo); // min of count and room
	assign adc_first = en_adc && (win_cnt == acq.adc_init_delay);

	// ========================================
	// latency shift and capture
	// ========================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			win_pipe <= '0;
			first_pipe <= '0;
			adc_data_valid <= 1'b0;
			echo_first_sample <= 1'b0;
		end
		else
		begin
			win_pipe <= {win_pipe[LAT-2:0], en_adc}; // several echoes may be in flight
			first_pipe <= {first_pipe[LAT-2:0], adc_first};
			adc_data_valid <= capture;
			echo_first_sample <= capture && first_pipe[LAT-1];
		end
	end

	assign capture = win_pipe[LAT-1]; // data for this conversion is on the pins now

	always_ff @(posedge pulseprog_clk)
	begin
		if (capture)
			adc_data_out <= {{(`NMR_ADC_DATA_WIDTH-`NMR_ADC_PHYS_WIDTH-1){1'b0}}, adc_ov, adc_in};
	end

	assign sample_valid = adc_data_valid;
	assign sample = adc_data_out[`NMR_ADC_PHYS_WIDTH-1:0]; // overflow bit dropped

endmodule

`default_nettype wire

// ==== nmr_cfg.svh ====
`ifndef NMR_CFG_SVH
`define NMR_CFG_SVH

// ========================================
// widths
// ========================================

// pulse and delay lengths in pulseprog_clk cycles
`define NMR_PULSE_WIDTH 32

// echo and sample counts
`define NMR_COUNT_WIDTH 32

`define NMR_ADC_PHYS_WIDTH 14 // adc magnitude bits
`define NMR_ADC_DATA_WIDTH 16 // {zero, overflow, sample}

// ========================================
// converter and downconversion
// ========================================

`define NMR_ADC_LATENCY 5 // conversion to data on the pins, in cycles

`define NMR_IQ_ROT_LEN 4 // quarter-rate rotation, samples per turn

`endif

// ==== nmr_controller_top.f ====
+incdir+.
nmr_seq_pkg.sv
nmr_data_pkg.sv
nmr_acq_if.sv
nmr_pulse_seq.sv
nmr_acq_window.sv
nmr_dconv.sv
nmr_controller_top.sv
tb_nmr_controller.sv

// ==== nmr_controller_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module nmr_controller_top
	import nmr_seq_pkg::*;
	import nmr_data_pkg::*;
(
	input  wire              pulseprog_clk,
	input  wire              rst,
	// control
	input  wire              start,
	input  wire              phase_cycle,
	// scan parameters
	input  wire pulse_len_t  pulse_t1,
	input  wire pulse_len_t  delay_t1,
	input  wire pulse_len_t  pulse_90,
	input  wire pulse_len_t  delay_nosig,
	input  wire pulse_len_t  pulse_180,
	input  wire pulse_len_t  delay_sig,
	input  wire count_t      echoes_per_scan,
	input  wire pulse_len_t  rx_delay,
	input  wire pulse_len_t  adc_init_delay,
	input  wire count_t      samples_per_echo,
	input  wire dc_value_t   dc_value,
	// adc pins
	input  wire adc_sample_t adc_in,
	input  wire              adc_ov,
	// status and rf
	output logic             fsmstat,
	output logic             rf_out_p,
	output logic             rf_out_n,
	// receiver
	output logic             en_rx,
	output logic             en_rx_dly,
	output logic             en_adc,
	// data
	output logic             adc_data_valid,
	output adc_word_t        adc_data_out,
	output logic             iq_valid,
	output iq_sample_t       data_i,
	output iq_sample_t       data_q
);

	logic        sample_valid;
	adc_sample_t sample;
	logic        echo_first_sample;

	nmr_acq_if acq_bus ();

	// ========================================
	// sequencer
	// ========================================

	nmr_pulse_seq nmr_pulse_seq_inst
	(
		.pulseprog_clk    (pulseprog_clk),
		.rst              (rst),
		.start            (start),
		.phase_cycle      (phase_cycle),
		.pulse_t1         (pulse_t1),
		.delay_t1         (delay_t1),
		.pulse_90         (pulse_90),
		.delay_nosig      (delay_nosig),
		.pulse_180        (pulse_180),
		.delay_sig        (delay_sig),
		.echoes_per_scan  (echoes_per_scan),
		.rx_delay         (rx_delay),
		.adc_init_delay   (adc_init_delay),
		.samples_per_echo (samples_per_echo),
		.fsmstat          (fsmstat),
		.rf_out_p         (rf_out_p),
		.rf_out_n         (rf_out_n),
		.acq              (acq_bus.seq)
	);

	// ========================================
	// acquisition
	// ========================================

	nmr_acq_window nmr_acq_window_inst
	(
		.pulseprog_clk     (pulseprog_clk),
		.rst               (rst),
		.adc_in            (adc_in),
		.adc_ov            (adc_ov),
		.acq               (acq_bus.acq),
		.en_rx             (en_rx),
		.en_rx_dly         (en_rx_dly),
		.en_adc            (en_adc),
		.adc_data_valid    (adc_data_valid),
		.adc_data_out      (adc_data_out),
		.sample_valid      (sample_valid),
		.sample            (sample),
		.echo_first_sample (echo_first_sample)
	);

	nmr_dconv nmr_dconv_inst
	(
		.pulseprog_clk     (pulseprog_clk),
		.rst               (rst),
		.sample_valid      (sample_valid),
		.sample            (sample),
		.echo_first_sample (echo_first_sample),
		.dc_value          (dc_value),
		.iq_valid          (iq_valid),
		.data_i            (data_i),
		.data_q            (data_q)
	);

endmodule

`default_nettype wire

// ==== nmr_data_pkg.sv ====
`default_nettype none

`include "nmr_cfg.svh"

package nmr_data_pkg;

	// ========================================
	// adc side
	// ========================================

	typedef logic [`NMR_ADC_PHYS_WIDTH-1:0] adc_sample_t; // unsigned magnitude
	typedef logic [`NMR_ADC_DATA_WIDTH-1:0] adc_word_t; // {0, ov, sample}

	// ========================================
	// downconversion side
	// ========================================

	// one bit wider than the sample so the offset can swing both ways
	typedef logic signed [`NMR_ADC_PHYS_WIDTH:0] dc_value_t;
	typedef logic signed [`NMR_ADC_PHYS_WIDTH:0] iq_sample_t; // signed i or q

endpackage

`default_nettype wire

// ==== nmr_dconv.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nmr_cfg.svh"

module nmr_dconv
	import nmr_data_pkg::*;
(
	input  wire              pulseprog_clk,
	input  wire              rst,
	input  wire              sample_valid,
	input  wire adc_sample_t sample, // unsigned magnitude
	input  wire              echo_first_sample, // restarts the rotation
	input  wire dc_value_t   dc_value, // signed offset to remove
	output logic             iq_valid,
	output iq_sample_t       data_i,
	output iq_sample_t       data_q
);

	localparam int ROT_BITS = $clog2(`NMR_IQ_ROT_LEN);

	logic [ROT_BITS-1:0] rot_idx; // index of the next sample in its echo
	logic [ROT_BITS-1:0] cur_idx; // index of the sample at the input
	iq_sample_t          v; // sample with dc removed
	iq_sample_t          v_neg;

	assign cur_idx = echo_first_sample ? '0 : rot_idx;
	assign v = $signed({1'b0, sample}) - dc_value; // zero-extend then subtract
	assign v_neg = -v;

	// ========================================
	// quarter-rate rotation
	// ========================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			rot_idx <= '0;
			iq_valid <= 1'b0;
		end
		else
		begin
			iq_valid <= sample_valid;
			if (sample_valid)
				rot_idx <= cur_idx + 1'b1; // wraps every four samples
		end
	end

	// cos/sin at fs/4 are 1,0,-1,0 and 0,1,0,-1
	always_ff @(posedge pulseprog_clk)
	begin
		if (sample_valid)
		begin
			case (cur_idx)
				2'd0:    begin data_i <= v;     data_q <= '0;    end
				2'd1:    begin data_i <= '0;    data_q <= v;     end
				2'd2:    begin data_i <= v_neg; data_q <= '0;    end
				default: begin data_i <= '0;    data_q <= v_neg; end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== nmr_pulse_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module nmr_pulse_seq
	import nmr_seq_pkg::*;
(
	input  wire             pulseprog_clk,
	input  wire             rst,
	input  wire             start, // one cycle, honoured only in idle
	input  wire             phase_cycle, // inverts the 90 pulse
	input  wire pulse_len_t pulse_t1,
	input  wire pulse_len_t delay_t1,
	input  wire pulse_len_t pulse_90,
	input  wire pulse_len_t delay_nosig,
	input  wire pulse_len_t pulse_180,
	input  wire pulse_len_t delay_sig,
	input  wire count_t     echoes_per_scan,
	input  wire pulse_len_t rx_delay,
	input  wire pulse_len_t adc_init_delay,
	input  wire count_t     samples_per_echo,
	output logic            fsmstat, // scan running
	output logic            rf_out_p,
	output logic            rf_out_n,
	nmr_acq_if.seq          acq
);

	seq_state_t state, nxt;
	seq_state_t first_echo, end_echo, enter_echo; // echo loop entry points
	seq_state_t from_p90, from_t1d, from_t1p; // linear part, zero phases skipped
	pulse_len_t phase_cnt; // cycles left in the phase, minus one
	pulse_len_t next_len; // length of the phase about to start
	count_t     echo_left; // echoes left including the current one
	logic       idle, advance, echo_end, carrier, in_pulse;

	// scan parameters, taken on start
	pulse_len_t lat_pulse_t1, lat_delay_t1, lat_pulse_90;
	pulse_len_t lat_delay_nosig, lat_pulse_180, lat_delay_sig;
	pulse_len_t lat_rx_delay, lat_adc_init_delay;
	count_t     lat_samples;
	logic       lat_phase_cycle;

	// effective values, inputs while idle so the first phase is picked on start
	pulse_len_t e_pulse_t1, e_delay_t1, e_pulse_90;
	pulse_len_t e_nosig, e_p180, e_sig;
	count_t     e_echoes;
	logic       e_phase;

	assign idle = (state == SEQ_IDLE);
	assign advance = idle ? start : (phase_cnt == '0); // load the next phase

	assign e_pulse_t1 = idle ? pulse_t1    : lat_pulse_t1;
	assign e_delay_t1 = idle ? delay_t1    : lat_delay_t1;
	assign e_pulse_90 = idle ? pulse_90    : lat_pulse_90;
	assign e_nosig    = idle ? delay_nosig : lat_delay_nosig;
	assign e_p180     = idle ? pulse_180   : lat_pulse_180;
	assign e_sig      = idle ? delay_sig   : lat_delay_sig;
	assign e_echoes   = idle ? echoes_per_scan : echo_left; // echo_left doubles as latch
	assign e_phase    = idle ? phase_cycle : lat_phase_cycle;

	// ========================================
	// next phase selection
	// ========================================

	always_comb
	begin
		first_echo = (e_nosig != '0) ? SEQ_DLY_NOSIG :
			(e_p180 != '0) ? SEQ_P180 : SEQ_DLY_SIG;
		end_echo = (e_echoes > 1) ? first_echo : SEQ_IDLE; // another echo or done
		// an echo with all three phases empty takes no time at all
		enter_echo = ((e_echoes != '0) && ((e_nosig | e_p180 | e_sig) != '0)) ?
			first_echo : SEQ_IDLE;
		from_p90 = (e_pulse_90 != '0) ? SEQ_P90 : enter_echo;
		from_t1d = (e_delay_t1 != '0) ? SEQ_T1_DELAY : from_p90;
		from_t1p = (e_pulse_t1 != '0) ? SEQ_T1_PULSE : from_t1d;
		echo_end = 1'b0;
		case (state)
			SEQ_IDLE:     nxt = from_t1p;
			SEQ_T1_PULSE: nxt = from_t1d;
			SEQ_T1_DELAY: nxt = from_p90;
			SEQ_P90:      nxt = enter_echo;
			SEQ_DLY_NOSIG:
			begin
				echo_end = (e_p180 == '0) && (e_sig == '0); // last phase of this echo
				nxt = (e_p180 != '0) ? SEQ_P180 :
					(e_sig != '0) ? SEQ_DLY_SIG : end_echo;
			end
			SEQ_P180:
			begin
				echo_end = (e_sig == '0);
				nxt = (e_sig != '0) ? SEQ_DLY_SIG : end_echo;
			end
			SEQ_DLY_SIG:
			begin
				echo_end = 1'b1;
				nxt = end_echo;
			end
			default:      nxt = SEQ_IDLE;
		endcase
	end

	always_comb
	begin
		case (nxt)
			SEQ_T1_PULSE:  next_len = e_pulse_t1;
			SEQ_T1_DELAY:  next_len = e_delay_t1;
			SEQ_P90:       next_len = e_pulse_90;
			SEQ_DLY_NOSIG: next_len = e_nosig;
			SEQ_P180:      next_len = e_p180;
			SEQ_DLY_SIG:   next_len = e_sig;
			default:       next_len = '0;
		endcase
	end

	// ========================================
	// state, counters, carrier
	// ========================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			state <= SEQ_IDLE;
			phase_cnt <= '0;
			echo_left <= '0;
			carrier <= 1'b0;
		end
		else if (advance)
		begin
			state <= nxt;
			phase_cnt <= next_len - 1'b1;
			carrier <= ~((nxt == SEQ_P90) && e_phase); // each pulse restarts the carrier
			if (idle)
				echo_left <= echoes_per_scan;
			else if (echo_end)
				echo_left <= echo_left - 1'b1;
		end
		else
		begin
			phase_cnt <= phase_cnt - 1'b1;
			carrier <= ~carrier; // half the clock rate
		end
	end

	always_ff @(posedge pulseprog_clk)
	begin
		if (idle && start)
		begin
			lat_pulse_t1 <= pulse_t1;
			lat_delay_t1 <= delay_t1;
			lat_pulse_90 <= pulse_90;
			lat_delay_nosig <= delay_nosig;
			lat_pulse_180 <= pulse_180;
			lat_delay_sig <= delay_sig;
			lat_rx_delay <= rx_delay;
			lat_adc_init_delay <= adc_init_delay;
			lat_samples <= samples_per_echo;
			lat_phase_cycle <= phase_cycle;
		end
	end

	assign in_pulse = (state == SEQ_T1_PULSE) || (state == SEQ_P90) || (state == SEQ_P180);
	assign rf_out_p = in_pulse & carrier;
	assign rf_out_n = in_pulse & ~carrier;
	assign fsmstat = ~idle;

	assign acq.sig_window = (state == SEQ_DLY_SIG);
	assign acq.rx_delay = lat_rx_delay;
	assign acq.adc_init_delay = lat_adc_init_delay;
	assign acq.samples_per_echo = lat_samples;

endmodule

`default_nettype wire

// ==== nmr_seq_pkg.sv ====
`default_nettype none

`include "nmr_cfg.svh"

package nmr_seq_pkg;

	// ========================================
	// timing types
	// ========================================

	typedef logic [`NMR_PULSE_WIDTH-1:0] pulse_len_t; // length in clock cycles
	typedef logic [`NMR_COUNT_WIDTH-1:0] count_t; // echo or sample count

	// ========================================
	// sequencer states
	// ========================================

	// scan order: t1 pulse, t1 delay, 90 pulse, then per echo
	// quiet delay, 180 pulse, signal delay
	typedef enum logic [2:0]
	{
		SEQ_IDLE      = 3'd0, // waiting for start
		SEQ_T1_PULSE  = 3'd1, // inversion pulse
		SEQ_T1_DELAY  = 3'd2, // recovery delay
		SEQ_P90       = 3'd3, // excitation
		SEQ_DLY_NOSIG = 3'd4, // quiet half of the echo spacing
		SEQ_P180      = 3'd5, // refocusing
		SEQ_DLY_SIG   = 3'd6  // echo forms, receiver open
	} seq_state_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_nmr_controller \
	-f nmr_controller_top.f

./obj_dir/Vtb_nmr_controller > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// ==== tb_nmr_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nmr_cfg.svh"

module tb_nmr_controller
	import nmr_seq_pkg::*;
	import nmr_data_pkg::*;
();

	localparam int LAT = `NMR_ADC_LATENCY;

	logic        pulseprog_clk = 1'b0;
	logic        rst;
	logic        start;
	logic        phase_cycle;
	pulse_len_t  pulse_t1, delay_t1, pulse_90;
	pulse_len_t  delay_nosig, pulse_180, delay_sig;
	count_t      echoes_per_scan;
	pulse_len_t  rx_delay, adc_init_delay;
	count_t      samples_per_echo;
	dc_value_t   dc_value;
	adc_sample_t adc_in;
	logic        adc_ov;
	logic        fsmstat, rf_out_p, rf_out_n;
	logic        en_rx, en_rx_dly, en_adc;
	logic        adc_data_valid, iq_valid;
	adc_word_t   adc_data_out;
	iq_sample_t  data_i, data_q;

	integer         seed = 53; // adc pin noise
	integer         rnd;
	logic           after_rst = 1'b0; // reset edge has reached the dut
	logic           started = 1'b0; // first start driven
	pulse_len_t     scan_cyc; // cycles since fsmstat rose
	pulse_len_t     ref_p90_at; // scan cycle where the 90 pulse opens
	logic           ref_p90_on;
	logic           ref_phase;
	logic [LAT:0]   adc_pipe; // en_adc lined up with adc_data_valid
	logic [LAT+1:0] rx_pipe; // en_rx lined up, extra bit for the edge
	logic           rx_rise; // first lined-up cycle of an echo
	adc_word_t      adc_prev; // pins as sampled at the last edge
	logic           valid_d;
	longint         n_cnt, n_cur; // sample index within the echo
	iq_sample_t     samp_v; // expected sample minus dc
	iq_sample_t     exp_i, exp_q;
	longint         fsm_cnt, rx_cnt, rxd_cnt, adc_cnt; // running high counts
	longint         en_adc_cnt; // conversion window cycles

	nmr_controller_top nmr_controller_top_inst (.*);

	initial
	begin
		forever
			#4 pulseprog_clk = ~pulseprog_clk; // 8 ns period
	end

	initial
	begin
		adc_in = '0;
		adc_ov = 1'b0;
		forever
		begin
			@(negedge pulseprog_clk);
			rnd = $random(seed);
			adc_in = rnd[`NMR_ADC_PHYS_WIDTH-1:0];
			adc_ov = rnd[31];
		end
	end

	// ========================================
	// reference model
	// ========================================

	assign rx_rise = rx_pipe[LAT] && !rx_pipe[LAT+1];
	assign n_cur = rx_rise ? 0 : n_cnt; // restart per echo
	assign samp_v = $signed({1'b0, adc_prev[`NMR_ADC_PHYS_WIDTH-1:0]}) - dc_value;

	always @(posedge pulseprog_clk)
	begin
		if (rst)
		begin
			after_rst <= 1'b1;
			scan_cyc <= '0;
			adc_pipe <= '0;
			rx_pipe <= '0;
			valid_d <= 1'b0;
			n_cnt <= 0;
			fsm_cnt <= 0;
			rx_cnt <= 0;
			rxd_cnt <= 0;
			adc_cnt <= 0;
			en_adc_cnt <= 0;
		end
		else
		begin
			scan_cyc <= fsmstat ? scan_cyc + 1 : '0;
			adc_pipe <= {adc_pipe[LAT-1:0], en_adc}; // latency plus output register
			rx_pipe <= {rx_pipe[LAT:0], en_rx};
			valid_d <= adc_data_valid;
			n_cnt <= n_cur + adc_data_valid;
			fsm_cnt <= fsm_cnt + fsmstat;
			rx_cnt <= rx_cnt + en_rx;
			rxd_cnt <= rxd_cnt + en_rx_dly;
			adc_cnt <= adc_cnt + adc_data_valid;
			en_adc_cnt <= en_adc_cnt + en_adc;
		end
		adc_prev <= {1'b0, adc_ov, adc_in};
	end

	// odd index lands on q, second half of the turn is negated
	always @(posedge pulseprog_clk)
	begin
		if (adc_data_valid)
		begin
			exp_i <= n_cur[0] ? '0 : (n_cur[1] ? -samp_v : samp_v);
			exp_q <= n_cur[0] ? (n_cur[1] ? -samp_v : samp_v) : '0;
		end
	end

	// ========================================
	// per-cycle checks, mid-cycle
	// ========================================

	assert property (@(negedge pulseprog_clk) !(after_rst && !started) ||
		({fsmstat, rf_out_p, rf_out_n, en_rx, en_rx_dly, en_adc, adc_data_valid, iq_valid} == 8'd0))
	else report_mismatch("reset_quiet", 0,
		{fsmstat, rf_out_p, rf_out_n, en_rx, en_rx_dly, en_adc, adc_data_valid, iq_valid});

	assert property (@(negedge pulseprog_clk) disable iff (rst) !(rf_out_p && rf_out_n))
	else report_mismatch("rf_exclusive", 0, 1);

	assert property (@(negedge pulseprog_clk) disable iff (rst)
		fsmstat || (!rf_out_p && !rf_out_n))
	else report_mismatch("rf_idle", 0, {rf_out_p, rf_out_n});

	assert property (@(negedge pulseprog_clk) disable iff (rst)
		!(fsmstat && ref_p90_on && (scan_cyc == ref_p90_at)) || (rf_out_p == !ref_phase))
	else report_mismatch("p90_first_cycle", !ref_phase, rf_out_p);

	assert property (@(negedge pulseprog_clk) disable iff (rst) adc_data_valid == adc_pipe[LAT])
	else report_mismatch("capture_timing", adc_pipe[LAT], adc_data_valid);

	assert property (@(negedge pulseprog_clk) disable iff (rst)
		!adc_data_valid || (adc_data_out == adc_prev))
	else report_mismatch("capture_data", adc_prev, adc_data_out);

	assert property (@(negedge pulseprog_clk) disable iff (rst) iq_valid == valid_d)
	else report_mismatch("iq_timing", valid_d, iq_valid);

	assert property (@(negedge pulseprog_clk) disable iff (rst) !iq_valid || (data_i == exp_i))
	else report_mismatch("iq_data_i", exp_i, data_i);

	assert property (@(negedge pulseprog_clk) disable iff (rst) !iq_valid || (data_q == exp_q))
	else report_mismatch("iq_data_q", exp_q, data_q);

	// ========================================
	// tasks
	// ========================================

	task automatic stop_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string test, input longint expected,
		input longint actual);
		$display("ERROR %s: expected %0d, actual %0d", test, expected, actual);
		stop_run();
	endtask

	task automatic wait_scan_end(input string name);
		int cycles = 0;
		while (fsmstat && cycles < 2000)
		begin
			@(negedge pulseprog_clk);
			cycles++;
		end
		if (fsmstat)
		begin
			$display("%s: scan still running after %0d cycles", name, cycles);
			stop_run();
		end
	endtask

	// captures trail the window, so wait for a quiet stretch longer than the pipe
	task automatic wait_drain(input string name);
		int cycles = 0;
		int quiet = 0;
		while (quiet < LAT + 2 && cycles < 100)
		begin
			@(negedge pulseprog_clk);
			cycles++;
			quiet = (adc_data_valid || iq_valid || en_adc) ? 0 : quiet + 1;
		end
		if (quiet < LAT + 2)
		begin
			$display("%s: sample outputs did not go quiet after the scan", name);
			stop_run();
		end
	endtask

	task automatic run_scan(input string name, input pulse_len_t pt1, input pulse_len_t dt1,
		input pulse_len_t p90, input pulse_len_t nosig, input pulse_len_t p180,
		input pulse_len_t sig, input count_t echoes, input pulse_len_t rxd,
		input pulse_len_t aid, input count_t spe, input logic phase, input dc_value_t dc);
		longint base_fsm, base_rx, base_rxd, base_adc, base_en_adc;
		longint exp_fsm, exp_rx, exp_rxd, exp_adc;
		longint window;
		pulse_t1 = pt1;
		delay_t1 = dt1;
		pulse_90 = p90;
		delay_nosig = nosig;
		pulse_180 = p180;
		delay_sig = sig;
		echoes_per_scan = echoes;
		rx_delay = rxd;
		adc_init_delay = aid;
		samples_per_echo = spe;
		phase_cycle = phase;
		dc_value = dc;
		ref_p90_at = pt1 + dt1; // zero phases take no cycles
		ref_p90_on = (p90 != '0);
		ref_phase = phase;
		window = (spe < sig - aid) ? spe : sig - aid;
		exp_fsm = pt1 + dt1 + p90 + echoes * (nosig + p180 + sig);
		exp_rx = echoes * sig;
		exp_rxd = echoes * (sig - rxd);
		exp_adc = echoes * window;
		base_fsm = fsm_cnt;
		base_rx = rx_cnt;
		base_rxd = rxd_cnt;
		base_adc = adc_cnt;
		base_en_adc = en_adc_cnt;
		start = 1'b1;
		started = 1'b1;
		@(negedge pulseprog_clk);
		start = 1'b0;
		assert (fsmstat) else report_mismatch({name, " fsmstat_rise"}, 1, fsmstat);
		// a second start and new values mid-scan, the latched set must hold
		repeat (12) @(negedge pulseprog_clk);
		start = 1'b1;
		pulse_t1 = pt1 + 40;
		delay_t1 = dt1 + 3;
		pulse_180 = p180 + 2;
		delay_sig = sig + 9;
		echoes_per_scan = echoes + 2;
		samples_per_echo = spe + 5;
		rx_delay = rxd + 1;
		adc_init_delay = aid + 1;
		phase_cycle = !phase;
		@(negedge pulseprog_clk);
		start = 1'b0;
		wait_scan_end(name);
		wait_drain(name);
		assert (fsm_cnt - base_fsm == exp_fsm)
		else report_mismatch({name, " scan_length"}, exp_fsm, fsm_cnt - base_fsm);
		assert (rx_cnt - base_rx == exp_rx)
		else report_mismatch({name, " en_rx_count"}, exp_rx, rx_cnt - base_rx);
		assert (rxd_cnt - base_rxd == exp_rxd)
		else report_mismatch({name, " en_rx_dly_count"}, exp_rxd, rxd_cnt - base_rxd);
		assert (en_adc_cnt - base_en_adc == exp_adc)
		else report_mismatch({name, " en_adc_count"}, exp_adc, en_adc_cnt - base_en_adc);
		assert (adc_cnt - base_adc == exp_adc)
		else report_mismatch({name, " capture_count"}, exp_adc, adc_cnt - base_adc);
	endtask

	// ========================================
	// stimulus
	// ========================================

	initial
	begin
		rst = 1'b1;
		start = 1'b0;
		phase_cycle = 1'b0;
		pulse_t1 = '0;
		delay_t1 = '0;
		pulse_90 = '0;
		delay_nosig = '0;
		pulse_180 = '0;
		delay_sig = '0;
		echoes_per_scan = '0;
		rx_delay = '0;
		adc_init_delay = '0;
		samples_per_echo = '0;
		dc_value = '0;
		ref_p90_at = '0;
		ref_p90_on = 1'b0;
		ref_phase = 1'b0;
		repeat (5) @(negedge pulseprog_clk);
		rst = 1'b0;
		repeat (3) @(negedge pulseprog_clk); // idle outputs checked here too
		// window capped by samples_per_echo
		run_scan("scan_plain", 6, 10, 4, 8, 6, 20, 3, 3, 4, 10, 1'b0, 1000);
		// no t1 pulse, inverted 90, window capped by the signal delay
		run_scan("scan_phase", 0, 7, 5, 3, 4, 12, 4, 5, 2, 20, 1'b1, 8192);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
